// ==== l2_pkg.sv ====
package l2_pkg;

  // Cache geometry
  localparam int WAYS       = 4;
  localparam int SETS       = 16;
  localparam int LINE_BYTES = 32;

  // Address split: tag | set | byte offset
  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int SET_W    = $clog2(SETS);
  localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;

  // Data widths
  localparam int LINE_W = LINE_BYTES * 8;
  localparam int WORD_W = 32;

  // Request bus transactions
  // GETS and GETM return a word, PUTM stores a whole line
  typedef enum logic [1:0] {
    NONE = 2'd0,
    GETS = 2'd1,
    GETM = 2'd2,
    PUTM = 2'd3
  } bus_tx_t;

endpackage

// ==== l2_way.sv ====
`timescale 1ns/1ps

module l2_way import l2_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [SET_W-1:0]  lookup_set,
  input  logic [TAG_W-1:0]  lookup_tag,
  input  logic              fill_en,
  input  logic              store_en,
  input  logic              victim,
  input  logic [LINE_W-1:0] fill_line,
  input  logic [LINE_W-1:0] store_line,
  output logic              hit,
  output logic              valid,
  output logic              dirty,
  output logic [TAG_W-1:0]  tag,
  output logic [LINE_W-1:0] line
);

  logic [TAG_W-1:0]  tag_mem  [SETS];
  logic [LINE_W-1:0] line_mem [SETS];
  logic [SETS-1:0]   valid_mem;
  logic [SETS-1:0]   dirty_mem;
  logic              do_fill;
  logic              do_store;

  // Asynchronous read of the addressed set
  assign valid = valid_mem[lookup_set];
  assign dirty = dirty_mem[lookup_set];
  assign tag   = tag_mem[lookup_set];
  assign hit   = valid && (tag == lookup_tag);

  // Fill goes to the victim way, store only to the way that hits
  assign do_fill  = fill_en && victim;
  assign do_store = store_en && hit;

  // Store data forwarded so a PUTM response carries the new word
  assign line = do_store ? store_line : line_mem[lookup_set];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_mem <= '0;
      dirty_mem <= '0;
    end else if (do_fill) begin
      valid_mem[lookup_set] <= 1'b1;
      dirty_mem[lookup_set] <= 1'b0;
    end else if (do_store) begin
      dirty_mem[lookup_set] <= 1'b1;
    end
  end

  // Line and tag storage
  always_ff @(posedge clk) begin
    if (do_fill) begin
      tag_mem[lookup_set]  <= lookup_tag;
      line_mem[lookup_set] <= fill_line;
    end else if (do_store) begin
      line_mem[lookup_set] <= store_line;
    end
  end

endmodule

// ==== l2_plru.sv ====
`timescale 1ns/1ps

module l2_plru import l2_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [SET_W-1:0] set,
  input  logic             update,
  input  logic [WAYS-1:0]  hit_vec,
  output logic [WAYS-1:0]  victim
);

  // Bit 0 picks the half, bit 1 ways 0-1, bit 2 ways 2-3
  logic [2:0] tree [SETS];
  logic [2:0] bits;
  logic [2:0] bits_next;

  assign bits = tree[set];

  // Follow the tree down to the victim
  always_comb begin
    victim = '0;
    if (!bits[0]) begin
      victim[{1'b0, bits[1]}] = 1'b1;
    end else begin
      victim[{1'b1, bits[2]}] = 1'b1;
    end
  end

  // Point every bit on the path away from the hit way
  always_comb begin
    bits_next = bits;
    if (hit_vec[0] || hit_vec[1]) begin
      bits_next[0] = 1'b1;
      bits_next[1] = hit_vec[0];
    end else if (hit_vec[2] || hit_vec[3]) begin
      bits_next[0] = 1'b0;
      bits_next[2] = hit_vec[2];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SETS; i++) begin
        tree[i] <= 3'b000;
      end
    end else if (update) begin
      tree[set] <= bits_next;
    end
  end

endmodule

// ==== l2_way_select.sv ====
`timescale 1ns/1ps

module l2_way_select import l2_pkg::*; (
  input  logic [WAYS-1:0]   hit_vec,
  input  logic [WAYS-1:0]   valid_vec,
  input  logic [WAYS-1:0]   dirty_vec,
  input  logic [TAG_W-1:0]  tag_vec  [WAYS],
  input  logic [LINE_W-1:0] line_vec [WAYS],
  input  logic [WAYS-1:0]   victim,
  input  logic [2:0]        word_sel,
  output logic              hit,
  output logic [WORD_W-1:0] resp_word,
  output logic              victim_dirty,
  output logic [TAG_W-1:0]  wb_tag,
  output logic [LINE_W-1:0] wb_line
);

  logic [LINE_W-1:0] hit_line;

  // Hit way feeds the response, victim way feeds the writeback
  always_comb begin
    hit          = 1'b0;
    hit_line     = '0;
    victim_dirty = 1'b0;
    wb_tag       = '0;
    wb_line      = '0;
    for (int i = 0; i < WAYS; i++) begin
      if (hit_vec[i]) begin
        hit      = 1'b1;
        hit_line = line_vec[i];
      end
      if (victim[i]) begin
        victim_dirty = valid_vec[i] && dirty_vec[i];
        wb_tag       = tag_vec[i];
        wb_line      = line_vec[i];
      end
    end
  end

  // Word at the request offset, rounded down to a word
  assign resp_word = hit_line[word_sel * WORD_W +: WORD_W];

endmodule

// ==== l2_control.sv ====
`timescale 1ns/1ps

module l2_control import l2_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  bus_tx_t           req_tx,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [LINE_W-1:0] req_line,
  input  logic              hit,
  input  logic              victim_dirty,
  input  logic [TAG_W-1:0]  wb_tag,
  input  logic              dfp_resp,
  output logic              req_busy,
  output logic              resp_valid,
  output logic [SET_W-1:0]  lookup_set,
  output logic [TAG_W-1:0]  lookup_tag,
  output logic [2:0]        word_sel,
  output logic [LINE_W-1:0] store_line,
  output logic              fill_en,
  output logic              store_en,
  output logic [ADDR_W-1:0] dfp_addr,
  output logic              dfp_read,
  output logic              dfp_write
);

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    FILL
  } state_t;

  state_t            state;
  state_t            state_next;
  bus_tx_t           tx_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LINE_W-1:0] line_q;
  logic              accept;

  assign accept = (state == IDLE) && req_valid;

  // Request held for the whole transaction
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_q   <= req_tx;
      addr_q <= req_addr;
      line_q <= req_line;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_next = IDLE;
        end else if (victim_dirty) begin
          state_next = WRITEBACK;
        end else begin
          state_next = FILL;
        end
      end
      WRITEBACK: begin
        if (dfp_resp) begin
          state_next = FILL;
        end
      end
      FILL: begin
        // Back to lookup, which now hits
        if (dfp_resp) begin
          state_next = LOOKUP;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  assign lookup_tag = addr_q[ADDR_W-1 -: TAG_W];
  assign lookup_set = addr_q[OFFSET_W +: SET_W];
  assign word_sel   = addr_q[OFFSET_W-1:2];
  assign store_line = line_q;

  assign req_busy   = (state != IDLE);
  assign resp_valid = (state == LOOKUP) && hit;
  assign store_en   = resp_valid && (tx_q == PUTM);
  assign fill_en    = (state == FILL) && dfp_resp;

  // Memory strobes follow the state directly
  assign dfp_write = (state == WRITEBACK);
  assign dfp_read  = (state == FILL);

  // Victim line address during writeback, request line otherwise
  always_comb begin
    if (state == WRITEBACK) begin
      dfp_addr = {wb_tag, lookup_set, {OFFSET_W{1'b0}}};
    end else begin
      dfp_addr = {lookup_tag, lookup_set, {OFFSET_W{1'b0}}};
    end
  end

endmodule

// ==== l2_slice.sv ====
`timescale 1ns/1ps

module l2_slice import l2_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  bus_tx_t           req_tx,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [LINE_W-1:0] req_line,
  input  logic [LINE_W-1:0] dfp_rdata,
  input  logic              dfp_resp,
  output logic              req_busy,
  output logic              resp_valid,
  output logic [WORD_W-1:0] resp_word,
  output logic [ADDR_W-1:0] dfp_addr,
  output logic              dfp_read,
  output logic              dfp_write,
  output logic [LINE_W-1:0] dfp_wdata
);

  logic              hit;
  logic              victim_dirty;
  logic [TAG_W-1:0]  wb_tag;
  logic [SET_W-1:0]  lookup_set;
  logic [TAG_W-1:0]  lookup_tag;
  logic [2:0]        word_sel;
  logic [LINE_W-1:0] store_line;
  logic              fill_en;
  logic              store_en;

  // Per-way read results
  logic [WAYS-1:0]   hit_vec;
  logic [WAYS-1:0]   valid_vec;
  logic [WAYS-1:0]   dirty_vec;
  logic [WAYS-1:0]   victim;
  logic [TAG_W-1:0]  tag_vec  [WAYS];
  logic [LINE_W-1:0] line_vec [WAYS];

  l2_control control (
    .clk          (clk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req_tx       (req_tx),
    .req_addr     (req_addr),
    .req_line     (req_line),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .wb_tag       (wb_tag),
    .dfp_resp     (dfp_resp),
    .req_busy     (req_busy),
    .resp_valid   (resp_valid),
    .lookup_set   (lookup_set),
    .lookup_tag   (lookup_tag),
    .word_sel     (word_sel),
    .store_line   (store_line),
    .fill_en      (fill_en),
    .store_en     (store_en),
    .dfp_addr     (dfp_addr),
    .dfp_read     (dfp_read),
    .dfp_write    (dfp_write)
  );

  for (genvar i = 0; i < WAYS; i++) begin : gen_way
    l2_way way (
      .clk        (clk),
      .rst        (rst),
      .lookup_set (lookup_set),
      .lookup_tag (lookup_tag),
      .fill_en    (fill_en),
      .store_en   (store_en),
      .victim     (victim[i]),
      .fill_line  (dfp_rdata),
      .store_line (store_line),
      .hit        (hit_vec[i]),
      .valid      (valid_vec[i]),
      .dirty      (dirty_vec[i]),
      .tag        (tag_vec[i]),
      .line       (line_vec[i])
    );
  end

  // Victim line goes straight out as write data
  l2_way_select way_select (
    .hit_vec      (hit_vec),
    .valid_vec    (valid_vec),
    .dirty_vec    (dirty_vec),
    .tag_vec      (tag_vec),
    .line_vec     (line_vec),
    .victim       (victim),
    .word_sel     (word_sel),
    .hit          (hit),
    .resp_word    (resp_word),
    .victim_dirty (victim_dirty),
    .wb_tag       (wb_tag),
    .wb_line      (dfp_wdata)
  );

  l2_plru plru (
    .clk     (clk),
    .rst     (rst),
    .set     (lookup_set),
    .update  (resp_valid),
    .hit_vec (hit_vec),
    .victim  (victim)
  );

endmodule

// ==== l2_slice_sva.sv ====
`timescale 1ns/1ps

module l2_slice_sva import l2_pkg::*; (
  input logic              clk,
  input logic              rst,
  input logic              req_busy,
  input logic              resp_valid,
  input logic              dfp_read,
  input logic              dfp_write,
  input logic              dfp_resp,
  input logic [ADDR_W-1:0] dfp_addr
);

  resp_one_cycle: assert property (
    @(posedge clk) disable iff (rst) resp_valid |=> !resp_valid
  ) else $error("resp_valid lasted more than one cycle");

  strobes_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(dfp_read && dfp_write)
  ) else $error("dfp_read and dfp_write high together");

  // Strobe and address stay put until memory answers
  read_hold: assert property (
    @(posedge clk) disable iff (rst)
    (dfp_read && !dfp_resp) |=> (dfp_read && $stable(dfp_addr))
  ) else $error("dfp_read or dfp_addr changed before dfp_resp");

  write_hold: assert property (
    @(posedge clk) disable iff (rst)
    (dfp_write && !dfp_resp) |=> (dfp_write && $stable(dfp_addr))
  ) else $error("dfp_write or dfp_addr changed before dfp_resp");

  busy_after_reset: assert property (
    @(posedge clk) rst |=> !req_busy
  ) else $error("req_busy high right after reset");

endmodule

// ==== tb_l2_slice.sv ====
`timescale 1ns/1ps

module tb_l2_slice import l2_pkg::*; ();

  localparam int MAX_TX         = 32;
  localparam int FIELDS         = 7;
  localparam int TIMEOUT_PER_TX = 40;
  localparam logic [WORD_W-1:0] MEM_PATTERN = 32'h5A5A_C3C3;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              req_valid = 1'b0;
  bus_tx_t           req_tx = NONE;
  logic [ADDR_W-1:0] req_addr = '0;
  logic [LINE_W-1:0] req_line = '0;
  logic [LINE_W-1:0] dfp_rdata = '0;
  logic              dfp_resp = 1'b0;
  logic              req_busy;
  logic              resp_valid;
  logic [WORD_W-1:0] resp_word;
  logic [ADDR_W-1:0] dfp_addr;
  logic              dfp_read;
  logic              dfp_write;
  logic [LINE_W-1:0] dfp_wdata;

  logic [31:0]       stim_mem [MAX_TX * FIELDS];
  int                tx_count = 0;
  logic              stim_ready = 1'b0;

  // Written-back lines and traffic counters of the memory model
  logic [LINE_W-1:0] mem_copy [logic [ADDR_W-1:0]];
  int unsigned       mem_wait = 0;
  int                wb_total = 0;
  int                fill_total = 0;
  logic [ADDR_W-1:0] last_wb_addr = '0;
  logic [ADDR_W-1:0] last_fill_addr = '0;

  l2_slice uut (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_tx     (req_tx),
    .req_addr   (req_addr),
    .req_line   (req_line),
    .dfp_rdata  (dfp_rdata),
    .dfp_resp   (dfp_resp),
    .req_busy   (req_busy),
    .resp_valid (resp_valid),
    .resp_word  (resp_word),
    .dfp_addr   (dfp_addr),
    .dfp_read   (dfp_read),
    .dfp_write  (dfp_write),
    .dfp_wdata  (dfp_wdata)
  );

  bind l2_control l2_slice_sva sva (
    .clk        (clk),
    .rst        (rst),
    .req_busy   (req_busy),
    .resp_valid (resp_valid),
    .dfp_read   (dfp_read),
    .dfp_write  (dfp_write),
    .dfp_resp   (dfp_resp),
    .dfp_addr   (dfp_addr)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // Untouched lines hold address XOR pattern in every word
  function automatic logic [LINE_W-1:0] read_line(input logic [ADDR_W-1:0] line_addr);
    logic [LINE_W-1:0] data;
    if (mem_copy.exists(line_addr)) begin
      return mem_copy[line_addr];
    end
    for (int w = 0; w < LINE_BYTES / 4; w++) begin
      data[w*WORD_W +: WORD_W] = (line_addr + 32'(w * 4)) ^ MEM_PATTERN;
    end
    return data;
  endfunction

  // Memory model answering 1 to 4 cycles after a strobe
  always @(posedge clk) begin
    if (rst) begin
      dfp_resp <= 1'b0;
      mem_wait = 0;
    end else if (dfp_resp) begin
      dfp_resp <= 1'b0;
    end else if (dfp_read || dfp_write) begin
      if (mem_wait == 0) begin
        mem_wait = 1 + ($urandom % 4);
      end
      mem_wait = mem_wait - 1;
      if (mem_wait == 0) begin
        dfp_resp <= 1'b1;
        if (dfp_write) begin
          mem_copy[dfp_addr] = dfp_wdata;
          last_wb_addr = dfp_addr;
          wb_total = wb_total + 1;
        end else begin
          dfp_rdata <= read_line(dfp_addr);
          last_fill_addr = dfp_addr;
          fill_total = fill_total + 1;
        end
      end
    end
  end

  task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Issue one stim line, wait for resp_valid and check the results
  task automatic run_tx(input int n);
    int                base;
    int                wb_start;
    int                fill_start;
    int                cycles;
    bus_tx_t           tx;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] putm_word;
    logic [WORD_W-1:0] exp_word;
    logic              exp_wb;
    logic [ADDR_W-1:0] exp_wb_addr;
    logic              exp_fill;
    base        = n * FIELDS;
    tx          = bus_tx_t'(stim_mem[base][1:0]);
    addr        = stim_mem[base + 1];
    putm_word   = stim_mem[base + 2];
    exp_word    = stim_mem[base + 3];
    exp_wb      = stim_mem[base + 4][0];
    exp_wb_addr = stim_mem[base + 5];
    exp_fill    = stim_mem[base + 6][0];
    while (req_busy) begin
      @(posedge clk);
    end
    wb_start   = wb_total;
    fill_start = fill_total;
    req_valid <= 1'b1;
    req_tx    <= tx;
    req_addr  <= addr;
    req_line  <= {8{putm_word}};
    @(posedge clk);
    req_valid <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!resp_valid);
    check_word("resp_word", resp_word, exp_word);
    check_flag("dfp_write", wb_total != wb_start, exp_wb);
    check_flag("dfp_write repeated", wb_total - wb_start > 1, 1'b0);
    check_flag("dfp_read", fill_total != fill_start, exp_fill);
    check_flag("dfp_read repeated", fill_total - fill_start > 1, 1'b0);
    if (exp_wb) begin
      check_addr("dfp_addr writeback", last_wb_addr, exp_wb_addr);
    end
    if (exp_fill) begin
      check_addr("dfp_addr fill", last_fill_addr, {addr[ADDR_W-1:OFFSET_W], 5'b0});
    end else if (!exp_wb) begin
      // Hits answer one cycle after acceptance
      check_flag("resp_valid one cycle after accept", cycles == 1, 1'b1);
    end
  endtask

  initial begin
    void'($urandom(31));
    for (int i = 0; i < MAX_TX * FIELDS; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("l2_stim.txt", stim_mem);
    // Code zero marks the end of the loaded lines
    while (tx_count < MAX_TX && stim_mem[tx_count * FIELDS] != 0) begin
      tx_count++;
    end
    stim_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_flag("req_busy", req_busy, 1'b0);
    check_flag("resp_valid", resp_valid, 1'b0);
    check_flag("dfp_read", dfp_read, 1'b0);
    check_flag("dfp_write", dfp_write, 1'b0);
    for (int n = 0; n < tx_count; n++) begin
      run_tx(n);
    end
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    wait (stim_ready);
    repeat ((tx_count + 2) * TIMEOUT_PER_TX) @(posedge clk);
    $display("Timeout: the transactions did not complete in time");
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule

// ==== sim.f ====
l2_pkg.sv
l2_way.sv
l2_plru.sv
l2_way_select.sv
l2_control.sv
l2_slice.sv
l2_slice_sva.sv
tb_l2_slice.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0 -Wno-fatal
TOP       = tb_l2_slice
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== l2_stim.txt ====
// code addr putm_word exp_word wb_flag wb_addr fill_flag
// code 1 = GETS, 2 = GETM, 3 = PUTM
1 00001024 00000000 5A5AD3E7 0 00000000 1
1 00001024 00000000 5A5AD3E7 0 00000000 0
2 0000103C 00000000 5A5AD3FF 0 00000000 0
3 00001028 DEADBEEF DEADBEEF 0 00000000 0
1 00001030 00000000 DEADBEEF 0 00000000 0
1 00002020 00000000 5A5AE3E3 0 00000000 1
1 00003020 00000000 5A5AF3E3 0 00000000 1
1 00004020 00000000 5A5A83E3 0 00000000 1
1 00005024 00000000 5A5A93E7 1 00001020 1
1 00001034 00000000 DEADBEEF 0 00000000 1
1 00002020 00000000 5A5AE3E3 0 00000000 1
3 000060A0 12345678 12345678 0 00000000 1
1 00001020 00000000 DEADBEEF 0 00000000 0
3 00004024 CAFEF00D CAFEF00D 0 00000000 0
1 00007020 00000000 5A5AB3E3 0 00000000 1
1 00008020 00000000 5A5A43E3 0 00000000 1
1 00009020 00000000 5A5A53E3 0 00000000 1
1 0000A020 00000000 5A5A63E3 1 00004020 1
2 00004028 00000000 CAFEF00D 0 00000000 1
